/* design/pu_pkg.sv */
package pu_pkg;

    localparam int data_width      = 32;
    localparam int attr_width      = 4;
    localparam int half_width      = 16;
    localparam int invalid_bit     = 0;
    localparam int acc_neg_bit     = 1; // a write with this bit set subtracts.
    localparam int acc_load_bit    = 2; // a write with this bit set replaces the sum.
    localparam int frac_bits       = 0;
    localparam int fram_depth      = 8;
    localparam int fram_addr_width = 3;

    typedef enum logic [0:0] {
        op_nop,
        op_move
    } pu_op_e;

    typedef enum logic [2:0] {
        unit_ext,
        unit_mul,
        unit_acc,
        unit_fram,
        unit_none
    } pu_unit_e;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [attr_width-1:0] attr;
    } bus_word_t;

    typedef struct packed {
        pu_op_e                     op;
        pu_unit_e                   src;
        logic                       dst_mul;
        logic                       dst_acc;
        logic                       dst_fram;
        logic                       dst_ext;
        logic [fram_addr_width-1:0] fram_addr;
        bus_word_t                  ext_word; // only driven when src is unit_ext.
    } pu_instr_t;

    typedef struct packed {
        logic wr;
        logic oe;
    } pu_strobe_t;

endpackage

/* design/pu_multiplier.sv */
`timescale 1ns/1ps

module pu_multiplier (
    input  logic                clk,
    input  logic                rst,
    input  pu_pkg::pu_strobe_t  ctl,
    input  pu_pkg::bus_word_t   din,
    output pu_pkg::bus_word_t   dout
);

    localparam int hi_width = pu_pkg::data_width - pu_pkg::half_width + 1;

    logic [pu_pkg::data_width-1:0] arg [2];
    logic                          arg_inv [2];
    logic                          arg_sel;

    logic                          sel_d;
    logic                          load_pending;
    logic                          invalid_value;

    logic [hi_width-1:0]           hi0;
    logic [hi_width-1:0]           hi1;
    logic                          range_ok0;
    logic                          range_ok1;

    logic signed [pu_pkg::data_width-1:0] product;
    logic [pu_pkg::data_width-1:0]        product_r;
    logic                                 invalid_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            arg_sel <= 1'b0;
        end else if (ctl.wr) begin
            arg[arg_sel]     <= din.data;
            arg_inv[arg_sel] <= din.attr[pu_pkg::invalid_bit];
            arg_sel          <= ~arg_sel;
        end
    end

    // the operand is in range when bits above bit 15 repeat its sign.
    assign hi0       = arg[0][pu_pkg::data_width-1:pu_pkg::half_width-1];
    assign hi1       = arg[1][pu_pkg::data_width-1:pu_pkg::half_width-1];
    assign range_ok0 = (&hi0) | ~(|hi0);
    assign range_ok1 = (&hi1) | ~(|hi1);

    assign product = $signed(arg[0][pu_pkg::half_width-1:0])
                   * $signed(arg[1][pu_pkg::half_width-1:0]);

    always_ff @(posedge clk) begin
        invalid_value <= arg_inv[0] | arg_inv[1] | ~range_ok0 | ~range_ok1;
        if (rst) begin
            sel_d        <= 1'b0;
            load_pending <= 1'b0;
        end else begin
            sel_d        <= arg_sel;
            load_pending <= ~arg_sel & sel_d; // toggle fell, so the second argument is in.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            product_r <= '0;
            invalid_r <= 1'b0;
        end else if (load_pending) begin
            product_r <= product >>> pu_pkg::frac_bits;
            invalid_r <= invalid_value;
        end
    end

    always_comb begin
        dout      = '0;
        dout.data = ctl.oe ? product_r : '0;
        dout.attr[pu_pkg::invalid_bit] = ctl.oe & invalid_r;
    end

    a_no_wr_with_oe: assert property (
        @(posedge clk) disable iff (rst) !(ctl.wr && ctl.oe)
    );

endmodule

/* design/pu_accum.sv */
`timescale 1ns/1ps

module pu_accum (
    input  logic                clk,
    input  logic                rst,
    input  pu_pkg::pu_strobe_t  ctl,
    input  pu_pkg::bus_word_t   din,
    output pu_pkg::bus_word_t   dout
);

    localparam int msb = pu_pkg::data_width - 1;

    logic [pu_pkg::data_width-1:0] sum;
    logic                          sum_invalid;

    logic [pu_pkg::data_width-1:0] result;
    logic                          do_sub;
    logic                          do_load;
    logic                          overflow;
    logic                          din_invalid;

    assign do_sub      = din.attr[pu_pkg::acc_neg_bit];
    assign do_load     = din.attr[pu_pkg::acc_load_bit];
    assign din_invalid = din.attr[pu_pkg::invalid_bit];

    assign result = do_sub ? sum - din.data : sum + din.data;

    always_comb begin
        if (do_sub) begin
            overflow = (sum[msb] != din.data[msb]) && (result[msb] != sum[msb]);
        end else begin
            overflow = (sum[msb] == din.data[msb]) && (result[msb] != sum[msb]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum         <= '0;
            sum_invalid <= 1'b0;
        end else if (ctl.wr) begin
            if (do_load) begin
                sum         <= din.data;
                sum_invalid <= din_invalid; // a load starts a fresh invalid history.
            end else begin
                sum         <= result;
                sum_invalid <= sum_invalid | overflow | din_invalid;
            end
        end
    end

    always_comb begin
        dout      = '0;
        dout.data = ctl.oe ? sum : '0;
        dout.attr[pu_pkg::invalid_bit] = ctl.oe & sum_invalid;
    end

endmodule

/* design/pu_fram.sv */
`timescale 1ns/1ps

module pu_fram (
    input  logic                               clk,
    input  pu_pkg::pu_strobe_t                 ctl,
    input  logic [pu_pkg::fram_addr_width-1:0] addr,
    input  pu_pkg::bus_word_t                  din,
    output pu_pkg::bus_word_t                  dout
);

    pu_pkg::bus_word_t mem [pu_pkg::fram_depth];

    always_ff @(posedge clk) begin
        if (ctl.wr) begin
            mem[addr] <= din; // data and attributes are stored together.
        end
    end

    // read is combinational so a read transfer completes in its own cycle.
    assign dout = ctl.oe ? mem[addr] : '0;

endmodule

/* design/pu_bus_ctrl.sv */
`timescale 1ns/1ps

module pu_bus_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               instr_stb,
    input  pu_pkg::pu_instr_t                  instr,
    input  pu_pkg::bus_word_t                  bus,
    output pu_pkg::bus_word_t                  ext_drive,
    output pu_pkg::pu_strobe_t                 mul_ctl,
    output pu_pkg::pu_strobe_t                 acc_ctl,
    output pu_pkg::pu_strobe_t                 fram_ctl,
    output logic [pu_pkg::fram_addr_width-1:0] fram_addr,
    output logic                               out_valid,
    output pu_pkg::bus_word_t                  out_word
);

    pu_pkg::pu_instr_t instr_r;
    logic              stb_r;
    logic              move;
    logic              ext_oe;

    always_ff @(posedge clk) begin
        if (rst) begin
            stb_r <= 1'b0;
        end else begin
            stb_r <= instr_stb;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_stb) begin
            instr_r <= instr;
        end
    end

    assign move = stb_r && (instr_r.op == pu_pkg::op_move);

    // src selects one output enable and the destination mask sets the write strobes.
    assign ext_oe      = move && (instr_r.src == pu_pkg::unit_ext);
    assign mul_ctl.oe  = move && (instr_r.src == pu_pkg::unit_mul);
    assign acc_ctl.oe  = move && (instr_r.src == pu_pkg::unit_acc);
    assign fram_ctl.oe = move && (instr_r.src == pu_pkg::unit_fram);

    assign mul_ctl.wr  = move && instr_r.dst_mul;
    assign acc_ctl.wr  = move && instr_r.dst_acc;
    assign fram_ctl.wr = move && instr_r.dst_fram;

    assign fram_addr = instr_r.fram_addr;
    assign ext_drive = ext_oe ? instr_r.ext_word : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_word  <= '0;
        end else begin
            out_valid <= move && instr_r.dst_ext;
            if (move && instr_r.dst_ext) begin
                out_word <= bus; // the bus holds the source word in the transfer cycle.
            end
        end
    end

    a_src_not_dst: assert property (
        @(posedge clk) disable iff (rst)
        instr_stb && (instr.op == pu_pkg::op_move) |=>
            !(mul_ctl.wr && mul_ctl.oe) &&
            !(acc_ctl.wr && acc_ctl.oe) &&
            !(fram_ctl.wr && fram_ctl.oe)
    );

endmodule

/* design/pu_net.sv */
`timescale 1ns/1ps

module pu_net (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_stb,
    input  pu_pkg::pu_instr_t instr,
    output logic              out_valid,
    output pu_pkg::bus_word_t out_word
);

    pu_pkg::bus_word_t  bus;
    pu_pkg::bus_word_t  ext_word;
    pu_pkg::bus_word_t  mul_word;
    pu_pkg::bus_word_t  acc_word;
    pu_pkg::bus_word_t  fram_word;

    pu_pkg::pu_strobe_t mul_ctl;
    pu_pkg::pu_strobe_t acc_ctl;
    pu_pkg::pu_strobe_t fram_ctl;

    logic [pu_pkg::fram_addr_width-1:0] fram_addr;

    // every idle party drives zeros, so the OR is the selected word.
    assign bus = ext_word | mul_word | acc_word | fram_word;

    pu_bus_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .instr_stb (instr_stb),
        .instr     (instr),
        .bus       (bus),
        .ext_drive (ext_word),
        .mul_ctl   (mul_ctl),
        .acc_ctl   (acc_ctl),
        .fram_ctl  (fram_ctl),
        .fram_addr (fram_addr),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    pu_multiplier mul_i (
        .clk  (clk),
        .rst  (rst),
        .ctl  (mul_ctl),
        .din  (bus),
        .dout (mul_word)
    );

    pu_accum acc_i (
        .clk  (clk),
        .rst  (rst),
        .ctl  (acc_ctl),
        .din  (bus),
        .dout (acc_word)
    );

    pu_fram fram_i (
        .clk  (clk),
        .ctl  (fram_ctl),
        .addr (fram_addr),
        .din  (bus),
        .dout (fram_word)
    );

endmodule

/* verif/pu_net_tb.sv */
`timescale 1ns/1ps

module pu_net_tb;

    localparam int     timeout_cycles = 20;
    localparam longint max_pos        = 64'sd2147483647;
    localparam longint min_neg        = -64'sd2147483648;

    logic              clk;
    logic              rst;
    logic              instr_stb;
    pu_pkg::pu_instr_t instr;
    logic              out_valid;
    pu_pkg::bus_word_t out_word;

    logic [31:0]       lfsr;

    logic [pu_pkg::data_width-1:0] ref_arg [2];
    logic                          ref_arg_inv [2];
    logic                          ref_arg_sel;
    pu_pkg::bus_word_t             ref_mul;
    logic [pu_pkg::data_width-1:0] ref_sum;
    logic                          ref_sum_inv;
    pu_pkg::bus_word_t             ref_fram [pu_pkg::fram_depth];

    logic              exp_now_valid;
    pu_pkg::bus_word_t exp_now_word;
    logic              exp_d1_valid;
    pu_pkg::bus_word_t exp_d1_word;
    logic              exp_d2_valid;
    pu_pkg::bus_word_t exp_d2_word;

    pu_net dut_i (
        .clk       (clk),
        .rst       (rst),
        .instr_stb (instr_stb),
        .instr     (instr),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // expected outputs pass through two stages to match the strobe to out_valid latency.
    always_ff @(posedge clk) begin
        if (rst) begin
            exp_d1_valid <= 1'b0;
            exp_d1_word  <= '0;
            exp_d2_valid <= 1'b0;
            exp_d2_word  <= '0;
        end else begin
            exp_d1_valid <= instr_stb && exp_now_valid;
            exp_d1_word  <= exp_now_word;
            exp_d2_valid <= exp_d1_valid;
            exp_d2_word  <= exp_d1_word;
        end
    end

    task automatic mismatch_failure(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic timeout_failure(input string what);
        $display("timed out waiting for %s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped on a timeout");
    endtask

    a_out_valid: assert property (
        @(posedge clk) disable iff (rst) out_valid == exp_d2_valid
    ) else mismatch_failure($sformatf("out_valid is %b, expected %b",
                                      $sampled(out_valid), $sampled(exp_d2_valid)));

    a_out_word: assert property (
        @(posedge clk) disable iff (rst) exp_d2_valid |-> out_word == exp_d2_word
    ) else mismatch_failure($sformatf("out_word is %h, expected %h",
                                      $sampled(out_word), $sampled(exp_d2_word)));

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // taps 32, 22, 2 and 1.
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_operand(output logic [31:0] v);
        logic [31:0] r;
        take_bits(pu_pkg::half_width, r);
        v = {{16{r[15]}}, r[15:0]};
    endtask

    function automatic pu_pkg::bus_word_t make_word(input logic [31:0] data,
                                                    input logic [3:0]  attr);
        pu_pkg::bus_word_t w;
        w.data = data;
        w.attr = attr;
        return w;
    endfunction

    function automatic pu_pkg::pu_instr_t make_move(input pu_pkg::pu_unit_e  src,
                                                    input logic              to_mul,
                                                    input logic              to_acc,
                                                    input logic              to_fram,
                                                    input logic              to_ext,
                                                    input logic [2:0]        addr,
                                                    input pu_pkg::bus_word_t w);
        pu_pkg::pu_instr_t ins;
        ins           = '0;
        ins.op        = pu_pkg::op_move;
        ins.src       = src;
        ins.dst_mul   = to_mul;
        ins.dst_acc   = to_acc;
        ins.dst_fram  = to_fram;
        ins.dst_ext   = to_ext;
        ins.fram_addr = addr;
        ins.ext_word  = w;
        return ins;
    endfunction

    function automatic logic in_range(input logic [31:0] x);
        return x == {{16{x[15]}}, x[15:0]};
    endfunction

    task automatic model_mul_write(input pu_pkg::bus_word_t w);
        int p;
        ref_arg[ref_arg_sel]     = w.data;
        ref_arg_inv[ref_arg_sel] = w.attr[pu_pkg::invalid_bit];
        if (ref_arg_sel) begin
            p = int'($signed(ref_arg[0][15:0])) * int'($signed(ref_arg[1][15:0]));
            ref_mul      = '0;
            ref_mul.data = p >>> pu_pkg::frac_bits;
            ref_mul.attr[pu_pkg::invalid_bit] = ref_arg_inv[0] | ref_arg_inv[1]
                                              | !in_range(ref_arg[0]) | !in_range(ref_arg[1]);
        end
        ref_arg_sel = ~ref_arg_sel;
    endtask

    task automatic model_acc_write(input pu_pkg::bus_word_t w);
        longint full;
        if (w.attr[pu_pkg::acc_load_bit]) begin
            ref_sum     = w.data;
            ref_sum_inv = w.attr[pu_pkg::invalid_bit];
        end else begin
            if (w.attr[pu_pkg::acc_neg_bit]) begin
                full = longint'($signed(ref_sum)) - longint'($signed(w.data));
            end else begin
                full = longint'($signed(ref_sum)) + longint'($signed(w.data));
            end
            ref_sum     = full[31:0];
            ref_sum_inv = ref_sum_inv | (full > max_pos) | (full < min_neg)
                        | w.attr[pu_pkg::invalid_bit];
        end
    endtask

    // all destinations sample the same bus word, so it is formed first.
    task automatic model_move(input  pu_pkg::pu_instr_t ins,
                              output logic              valid,
                              output pu_pkg::bus_word_t word);
        pu_pkg::bus_word_t bus_w;
        valid = 1'b0;
        word  = '0;
        bus_w = '0;
        if (ins.op == pu_pkg::op_move) begin
            case (ins.src)
                pu_pkg::unit_ext:  bus_w = ins.ext_word;
                pu_pkg::unit_mul:  bus_w = ref_mul;
                pu_pkg::unit_acc: begin
                    bus_w.data = ref_sum;
                    bus_w.attr[pu_pkg::invalid_bit] = ref_sum_inv;
                end
                pu_pkg::unit_fram: bus_w = ref_fram[ins.fram_addr];
                default:           bus_w = '0;
            endcase
            if (ins.dst_mul) model_mul_write(bus_w);
            if (ins.dst_acc) model_acc_write(bus_w);
            if (ins.dst_fram) ref_fram[ins.fram_addr] = bus_w;
            valid = ins.dst_ext;
            word  = bus_w;
        end
    endtask

    task automatic issue(input pu_pkg::pu_instr_t ins);
        logic              valid;
        pu_pkg::bus_word_t word;
        @(negedge clk);
        model_move(ins, valid, word);
        instr         = ins;
        instr_stb     = 1'b1;
        exp_now_valid = valid;
        exp_now_word  = word;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_stb     = 1'b0;
            exp_now_valid = 1'b0;
        end
    endtask

    task automatic wait_for_output();
        int waited;
        idle_cycles(1);
        waited = 0;
        while (!out_valid) begin
            if (waited == timeout_cycles) begin
                timeout_failure("out_valid after a read to the external port");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        idle_cycles(1);
        waited = 0;
        while (exp_d1_valid || exp_d2_valid || out_valid) begin
            if (waited == timeout_cycles) begin
                timeout_failure("the last outputs to drain");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic read_to_ext(input pu_pkg::pu_unit_e src, input logic [2:0] addr);
        issue(make_move(src, 1'b0, 1'b0, 1'b0, 1'b1, addr, '0));
        wait_for_output();
    endtask

    task automatic write_from_ext(input logic to_mul, input logic to_acc, input logic to_fram,
                                  input logic [2:0] addr, input pu_pkg::bus_word_t w);
        issue(make_move(pu_pkg::unit_ext, to_mul, to_acc, to_fram, 1'b0, addr, w));
    endtask

    // product must be registered before the read, hence two idle cycles.
    task automatic multiply(input pu_pkg::bus_word_t a, input pu_pkg::bus_word_t b);
        write_from_ext(1'b1, 1'b0, 1'b0, 3'd0, a);
        write_from_ext(1'b1, 1'b0, 1'b0, 3'd0, b);
        idle_cycles(2);
    endtask

    initial begin
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       r;
        pu_pkg::pu_instr_t ins;
        lfsr          = 32'h2fb1;
        rst           = 1'b1;
        instr_stb     = 1'b0;
        instr         = '0;
        exp_now_valid = 1'b0;
        exp_now_word  = '0;
        ref_arg[0]    = '0;
        ref_arg[1]    = '0;
        ref_arg_inv[0] = 1'b0;
        ref_arg_inv[1] = 1'b0;
        ref_arg_sel   = 1'b0;
        ref_mul       = '0;
        ref_sum       = '0;
        ref_sum_inv   = 1'b0;
        for (int i = 0; i < pu_pkg::fram_depth; i++) begin
            ref_fram[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_to_ext(pu_pkg::unit_acc, 3'd0);
        read_to_ext(pu_pkg::unit_mul, 3'd0);

        for (int i = 0; i < 4; i++) begin
            take_bits(32, a);
            take_bits(4, r);
            issue(make_move(pu_pkg::unit_ext, 1'b0, 1'b0, 1'b0, 1'b1, 3'd0,
                            make_word(a, r[3:0])));
            wait_for_output();
        end
        ins    = make_move(pu_pkg::unit_ext, 1'b0, 1'b0, 1'b0, 1'b1, 3'd0, make_word(a, 4'h0));
        ins.op = pu_pkg::op_nop; // a nop with dst_ext set must stay silent.
        issue(ins);
        issue(make_move(pu_pkg::unit_ext, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, make_word(a, 4'h0)));
        idle_cycles(4);

        for (int i = 0; i < 6; i++) begin
            rand_operand(a);
            rand_operand(b);
            multiply(make_word(a, 4'h0), make_word(b, 4'h0));
            read_to_ext(pu_pkg::unit_mul, 3'd0);
        end
        rand_operand(a);
        rand_operand(b);
        multiply(make_word(a ^ 32'h0004_0000, 4'h0), make_word(b, 4'h0));
        read_to_ext(pu_pkg::unit_mul, 3'd0);
        multiply(make_word(a, 4'h0), make_word(b, 4'h1));
        read_to_ext(pu_pkg::unit_mul, 3'd0);
        multiply(make_word(a, 4'h0), make_word(b, 4'h0));
        read_to_ext(pu_pkg::unit_mul, 3'd0);

        take_bits(32, a);
        write_from_ext(1'b0, 1'b1, 1'b0, 3'd0, make_word(a, 4'b0100));
        read_to_ext(pu_pkg::unit_acc, 3'd0);
        for (int i = 0; i < 10; i++) begin
            take_bits(32, a);
            take_bits(1, r);
            write_from_ext(1'b0, 1'b1, 1'b0, 3'd0, make_word(a, {2'b00, r[0], 1'b0}));
            read_to_ext(pu_pkg::unit_acc, 3'd0);
            if (i == 4) begin
                write_from_ext(1'b0, 1'b1, 1'b0, 3'd0, make_word(a, 4'b0100));
                read_to_ext(pu_pkg::unit_acc, 3'd0);
            end
        end
        write_from_ext(1'b0, 1'b1, 1'b0, 3'd0, make_word(32'd0, 4'b0100));
        write_from_ext(1'b0, 1'b1, 1'b0, 3'd0, make_word(32'd7, 4'b0001));
        read_to_ext(pu_pkg::unit_acc, 3'd0);

        for (int i = 0; i < pu_pkg::fram_depth; i++) begin
            take_bits(32, a);
            take_bits(4, r);
            write_from_ext(1'b0, 1'b0, 1'b1, i[2:0], make_word(a, r[3:0]));
        end
        for (int i = 0; i < 8; i++) begin
            take_bits(32, a);
            take_bits(7, r);
            write_from_ext(1'b0, 1'b0, 1'b1, r[2:0], make_word(a, r[6:3]));
            read_to_ext(pu_pkg::unit_fram, r[2:0]);
        end

        write_from_ext(1'b0, 1'b1, 1'b0, 3'd0, make_word(32'd0, 4'b0100));
        rand_operand(a);
        rand_operand(b);
        multiply(make_word(a, 4'h0), make_word(b, 4'h0));
        issue(make_move(pu_pkg::unit_mul, 1'b0, 1'b0, 1'b1, 1'b0, 3'd5, '0));
        issue(make_move(pu_pkg::unit_fram, 1'b0, 1'b1, 1'b0, 1'b0, 3'd5, '0));
        read_to_ext(pu_pkg::unit_acc, 3'd0);
        read_to_ext(pu_pkg::unit_fram, 3'd5);

        wait_for_drain();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* verilog.f */
design/pu_pkg.sv
design/pu_multiplier.sv
design/pu_accum.sv
design/pu_fram.sv
design/pu_bus_ctrl.sv
design/pu_net.sv
verif/pu_net_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pu_net_tb -f verilog.f -o pu_net_sim

sim_output=$(./obj_dir/pu_net_sim || true)
echo "$sim_output"

if echo "$sim_output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
